// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/load_ctrl.sv
verilog/inst_mem.sv
verilog/alu.sv
verilog/exec_core.sv
verilog/data_mem.sv
verilog/byte_out.sv
verilog/cpu_top.sv
tests/cpu_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = cpu_tb
RTL_TOP  = cpu_top
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = 'All tests passed!'

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q $(PASS) $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/cpu_patterns.txt ====
# kind value: P program word (hex, in address order), I input byte, O expected output byte
# alu section
P 20010005
P 20020003
P 00221820
P 6C030000
P 00222022
P 6C040000
P 00222824
P 6C050000
P 00223025
P 6C060000
P 00223827
P 6C070000
P 00014100
P 6C080000
P 00084882
P 6C090000
P 0041502A
P 6C0A0000
P 200BFFFF
P 296C0000
P 6C0C0000
P 316D00A5
P 6C0D0000
P 344E0040
P 6C0E0000
P 3C0F1234
P 000F8402
P 6C100000
# store and load
P AC490007
P 8C11000A
P 6C110000
# branches and jumps
P 10210002
P 6C0B0000
P 14220002
P 6C0B0000
P 14210002
P 6C030000
P 10220002
P 6C040000
P 08000029
P 6C0B0000
P 0C000036
P 6C050000
# input stream, plus one
P 20120000
P 68120000
P 22520001
P 6C120000
P 68120000
P 22520001
P 6C120000
P 68120000
P 22520001
P 6C120000
P 08000035
# subroutine
P 6C0E0000
P 03E00008
I 41
I FF
I 7F
O 08
O 02
O 01
O 07
O F8
O 50
O 14
O 01
O 01
O A5
O 43
O 34
O 14
O 08
O 02
O 43
O 01
O 42
O 00
O 80

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	logic CLK;
	logic rst;
	logic load_req;
	logic run_req;
	byte_t in_data;
	logic in_valid;
	logic in_ready;
	byte_t out_data;
	logic out_valid;
	logic out_ready;
	mode_e mode;

	word_t prog_q [$];
	byte_t in_q [$];
	byte_t exp_q [$];

	int byte_errors = 0;
	int mode_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int limit = 0;
	int n_records = 0;

	cpu_top #(.IMEM_AW(10), .DMEM_AW(10)) dut (
		.CLK(CLK),
		.rst(rst),
		.load_req(load_req),
		.run_req(run_req),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.mode(mode)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// ******************************
	// checks
	// ******************************
	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %02h got %02h", $time, name, exp, act);
			byte_errors++;
		end
	endtask

	task automatic check_mode(input mode_e exp, input mode_e act);
		if (exp !== act) begin
			$display("[ERROR] %0t mode expected %s got %s", $time, exp.name(), act.name());
			mode_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
			other_errors++;
		end
	endtask

	task automatic read_patterns();
		int fd;
		int code;
		byte kind;
		logic [31:0] value;
		string line;
		fd = $fopen("tests/cpu_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				break;
			if (kind == "#") begin
				code = $fgets(line, fd);   // comment line
				continue;
			end
			code = $fscanf(fd, "%h", value);
			n_records++;
			case (kind)
				"P": prog_q.push_back(value);
				"I": in_q.push_back(value[7:0]);
				"O": exp_q.push_back(value[7:0]);
				default: begin
					$display("unknown record kind in the pattern file");
					other_errors++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic idle_gap();
		repeat ($urandom % 3) begin
			in_valid <= 1'b0;
			@(posedge CLK);
		end
	endtask

	// ******************************
	// stimulus
	// ******************************
	task automatic load_program();
		foreach (prog_q[i]) begin
			for (int b = 0; b < 4; b++) begin
				idle_gap();
				in_valid <= 1'b1;
				in_data <= prog_q[i][8*b +: 8];   // low byte first
				@(negedge CLK);
				check_flag("in_ready", 1'b1, in_ready);
				@(posedge CLK);
			end
		end
		in_valid <= 1'b0;
	endtask

	task automatic feed_inputs();
		foreach (in_q[i]) begin
			idle_gap();
			in_valid <= 1'b1;
			in_data <= in_q[i];
			do
				@(negedge CLK);
			while (!in_ready);
			@(posedge CLK);
		end
		in_valid <= 1'b0;
	endtask

	task automatic watch_outputs();
		int got;
		got = 0;
		while (got < exp_q.size()) begin
			@(posedge CLK);
			out_ready <= ($urandom % 4) != 0;   // drop ready about a quarter of the time
			@(negedge CLK);
			if (out_valid && out_ready) begin
				check_byte("out_data", exp_q[got], out_data);
				got++;
			end
		end
		@(posedge CLK);
		out_ready <= 1'b1;
		repeat (20) begin
			@(negedge CLK);
			if (out_valid) begin
				$display("unexpected extra output byte %02h", out_data);
				other_errors++;
			end
		end
	endtask

	always @(posedge CLK) begin
		cycles++;
		if (limit != 0 && cycles >= limit) begin
			$display("the run timed out after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h5ea0));
		rst = 1'b1;
		load_req = 1'b0;
		run_req = 1'b0;
		in_data = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		read_patterns();
		limit = 40 * n_records + 500;

		repeat (3) @(posedge CLK);
		rst <= 1'b0;
		@(negedge CLK);
		check_mode(MODE_LOAD, mode);
		check_flag("out_valid", 1'b0, out_valid);

		@(posedge CLK);
		load_program();
		@(posedge CLK);
		run_req <= 1'b1;
		@(posedge CLK);
		run_req <= 1'b0;
		@(negedge CLK);
		check_mode(MODE_EXEC, mode);

		@(posedge CLK);
		fork
			feed_inputs();
			watch_outputs();
		join

		@(posedge CLK);
		load_req <= 1'b1;
		@(posedge CLK);
		load_req <= 1'b0;
		@(negedge CLK);
		check_mode(MODE_LOAD, mode);

		$display("errors: output %0d, mode %0d, other %0d",
			byte_errors, mode_errors, other_errors);
		if (byte_errors + mode_errors + other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
	parameter int IMEM_AW = 10,
	parameter int DMEM_AW = 10
) (
	input logic CLK,
	input logic rst,
	input logic load_req,
	input logic run_req,
	input cpu_pkg::byte_t in_data,
	input logic in_valid,
	output logic in_ready,
	output cpu_pkg::byte_t out_data,
	output logic out_valid,
	input logic out_ready,
	output cpu_pkg::mode_e mode
);
	import cpu_pkg::*;

	// ******************************
	// input side
	// ******************************
	byte_t core_in_data;
	logic core_in_valid;
	logic core_in_ready;
	logic start;
	imem_wr_t imem_wr;
	pc_t imem_addr;
	word_t imem_data;

	load_ctrl u_load_ctrl (
		.CLK(CLK),
		.rst(rst),
		.load_req(load_req),
		.run_req(run_req),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.core_in_ready(core_in_ready),
		.core_in_data(core_in_data),
		.core_in_valid(core_in_valid),
		.mode(mode),
		.start(start),
		.imem_wr(imem_wr)
	);

	inst_mem #(.IMEM_AW(IMEM_AW)) u_inst_mem (
		.CLK(CLK),
		.imem_wr(imem_wr),
		.imem_addr(imem_addr),
		.imem_data(imem_data)
	);

	// ******************************
	// processing part
	// ******************************
	dmem_req_t dmem_req;
	word_t dmem_rdata;
	byte_t core_out_data;
	logic core_out_valid;
	logic core_out_ready;

	exec_core u_exec_core (
		.CLK(CLK),
		.rst(rst),
		.mode(mode),
		.start(start),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata),
		.core_in_data(core_in_data),
		.core_in_valid(core_in_valid),
		.core_in_ready(core_in_ready),
		.core_out_data(core_out_data),
		.core_out_valid(core_out_valid),
		.core_out_ready(core_out_ready)
	);

	data_mem #(.DMEM_AW(DMEM_AW)) u_data_mem (
		.CLK(CLK),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata)
	);

	// output side
	byte_out u_byte_out (
		.CLK(CLK),
		.rst(rst),
		.core_out_data(core_out_data),
		.core_out_valid(core_out_valid),
		.core_out_ready(core_out_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// ==== verilog/byte_out.sv ====
`timescale 1ns/1ps

module byte_out (
	input logic CLK,
	input logic rst,
	input cpu_pkg::byte_t core_out_data,
	input logic core_out_valid,
	output logic core_out_ready,
	output cpu_pkg::byte_t out_data,
	output logic out_valid,
	input logic out_ready
);
	import cpu_pkg::*;

	byte_t data_q;
	logic full;
	logic accept;

	// free, or draining this cycle
	assign core_out_ready = !full || out_ready;
	assign accept = core_out_valid && core_out_ready;

	always_ff @(posedge CLK) begin
		if (rst)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
		else if (out_ready)
			full <= 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (accept)
			data_q <= core_out_data;
	end

	assign out_valid = full;
	assign out_data = data_q;

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
	parameter int DMEM_AW = 10
) (
	input logic CLK,
	input cpu_pkg::dmem_req_t dmem_req,
	output cpu_pkg::word_t dmem_rdata
);
	import cpu_pkg::*;

	word_t mem [2**DMEM_AW];
	logic [DMEM_AW-1:0] idx;

	assign idx = dmem_req.addr[DMEM_AW-1:0];   // wraps on the low bits

	always_ff @(posedge CLK) begin
		if (dmem_req.we)
			mem[idx] <= dmem_req.wdata;
		dmem_rdata <= mem[idx];   // one cycle read
	end

endmodule

// ==== verilog/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
	input logic CLK,
	input logic rst,
	input cpu_pkg::mode_e mode,
	input logic start,
	output cpu_pkg::pc_t imem_addr,
	input cpu_pkg::word_t imem_data,
	output cpu_pkg::dmem_req_t dmem_req,
	input cpu_pkg::word_t dmem_rdata,
	input cpu_pkg::byte_t core_in_data,
	input logic core_in_valid,
	output logic core_in_ready,
	output cpu_pkg::byte_t core_out_data,
	output logic core_out_valid,
	input logic core_out_ready
);
	import cpu_pkg::*;

	word_t regs [32];
	pc_t pc;
	pc_t pc_next;
	exec_state_e state;

	// ******************************
	// decode
	// ******************************
	opcode_t opcode;
	funct_t funct;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	logic [15:0] imm;
	word_t rs_val;
	word_t rt_val;
	logic is_jr;
	logic is_jalr;
	logic is_j;
	logic is_jal;
	logic is_lw;
	logic is_sw;
	logic is_in;
	logic is_out;
	logic active;
	logic hold;
	logic advance;

	assign opcode = imem_data[31:26];
	assign rs = imem_data[25:21];
	assign rt = imem_data[20:16];
	assign rd = imem_data[15:11];
	assign funct = imem_data[5:0];
	assign imm = imem_data[15:0];

	assign rs_val = (rs == '0) ? '0 : regs[rs];   // r0 reads as zero
	assign rt_val = (rt == '0) ? '0 : regs[rt];

	assign is_jr = opcode == OP_SPECIAL && funct == FUNCT_JR;
	assign is_jalr = opcode == OP_SPECIAL && funct == FUNCT_JALR;
	assign is_j = opcode == OP_J;
	assign is_jal = opcode == OP_JAL;
	assign is_lw = opcode == OP_LW;
	assign is_sw = opcode == OP_SW;
	assign is_in = opcode == OP_IN;
	assign is_out = opcode == OP_OUT;

	assign active = mode == MODE_EXEC && !start;

	// ******************************
	// alu
	// ******************************
	alu_op_t alu_op;
	word_t alu_result;
	logic take_branch;

	assign alu_op.opcode = opcode;
	assign alu_op.funct = funct;
	assign alu_op.shamt = imem_data[10:6];
	assign alu_op.imm = imm;
	assign alu_op.a = (is_jal || is_jalr) ? word_t'(pc) : rs_val;
	assign alu_op.b = rt_val;

	alu u_alu (
		.op(alu_op),
		.result(alu_result),
		.take_branch(take_branch)
	);

	always_comb begin
		hold = 1'b0;
		if (is_in && !core_in_valid)
			hold = 1'b1;
		if (is_out && !core_out_ready)
			hold = 1'b1;
		if (is_lw && state == ST_ISSUE)
			hold = 1'b1;   // wait for registered read
	end

	assign advance = active && !hold;

	// ******************************
	// writeback
	// ******************************
	logic wb_en;
	reg_idx_t wb_idx;
	word_t wb_data;

	always_comb begin
		wb_en = 1'b0;
		wb_idx = rt;
		wb_data = alu_result;
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_NOR,
					FUNCT_SLL, FUNCT_SRL, FUNCT_SLT: begin
						wb_en = 1'b1;
						wb_idx = rd;
					end
					FUNCT_JALR: begin
						wb_en = 1'b1;
						wb_idx = 5'd31;
					end
					default: wb_en = 1'b0;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_SLTI, OP_LUI: wb_en = 1'b1;
			OP_JAL: begin
				wb_en = 1'b1;
				wb_idx = 5'd31;
			end
			OP_LW: begin
				wb_en = 1'b1;
				wb_data = dmem_rdata;
			end
			OP_IN: begin
				wb_en = 1'b1;
				wb_data = {rt_val[31:8], core_in_data};   // upper bits kept
			end
			default: wb_en = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (advance && wb_en)
			regs[wb_idx] <= wb_data;
	end

	always_comb begin
		pc_next = pc + pc_t'(1);
		if (is_j || is_jal)
			pc_next = imm;
		else if (is_jr || is_jalr)
			pc_next = rs_val[15:0];
		else if (take_branch)
			pc_next = pc + imm;   // offset from the branch itself
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= '0;
			state <= ST_ISSUE;
		end else if (start) begin
			pc <= '0;
			state <= ST_ISSUE;
		end else if (active) begin
			if (advance)
				pc <= pc_next;
			case (state)
				ST_ISSUE    : state <= is_lw ? ST_LOAD_WAIT : ST_ISSUE;
				ST_LOAD_WAIT: state <= ST_ISSUE;
				default     : state <= ST_ISSUE;
			endcase
		end
	end

	assign imem_addr = pc;

	assign dmem_req.we = active && is_sw;
	assign dmem_req.addr = rs_val + {{16{imm[15]}}, imm};
	assign dmem_req.wdata = rt_val;

	assign core_in_ready = active && is_in;
	assign core_out_valid = active && is_out;
	assign core_out_data = rt_val[7:0];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t result,
	output logic take_branch
);
	import cpu_pkg::*;

	word_t imm_sext;
	word_t imm_zext;
	logic lt_reg;
	logic lt_imm;

	assign imm_sext = {{16{op.imm[15]}}, op.imm};
	assign imm_zext = {16'b0, op.imm};
	assign lt_reg = $signed(op.a) < $signed(op.b);
	assign lt_imm = $signed(op.a) < $signed(imm_sext);

	always_comb begin
		result = '0;
		take_branch = 1'b0;
		case (op.opcode)
			OP_SPECIAL: begin
				case (op.funct)
					FUNCT_ADD : result = op.a + op.b;
					FUNCT_SUB : result = op.a - op.b;
					FUNCT_AND : result = op.a & op.b;
					FUNCT_OR  : result = op.a | op.b;
					FUNCT_NOR : result = ~(op.a | op.b);
					FUNCT_SLL : result = op.b << op.shamt;
					FUNCT_SRL : result = op.b >> op.shamt;
					FUNCT_SLT : result = {31'b0, lt_reg};
					FUNCT_JALR: result = op.a + 32'd1;   // a carries pc here
					default   : result = '0;
				endcase
			end
			OP_ADDI: result = op.a + imm_sext;
			OP_ANDI: result = op.a & imm_zext;
			OP_ORI : result = op.a | imm_zext;
			OP_SLTI: result = {31'b0, lt_imm};
			OP_LUI : result = {op.imm, 16'b0};
			OP_JAL : result = op.a + 32'd1;   // link
			OP_BEQ : take_branch = op.a == op.b;
			OP_BNE : take_branch = op.a != op.b;
			default: result = '0;
		endcase
	end

endmodule

// ==== verilog/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
	parameter int IMEM_AW = 10
) (
	input logic CLK,
	input cpu_pkg::imem_wr_t imem_wr,
	input cpu_pkg::pc_t imem_addr,
	output cpu_pkg::word_t imem_data
);
	import cpu_pkg::*;

	word_t mem [2**IMEM_AW];

	always_ff @(posedge CLK) begin
		if (imem_wr.en)
			mem[imem_wr.addr[IMEM_AW-1:0]] <= imem_wr.data;
	end

	// fetch is combinational, the core decodes in the same cycle
	assign imem_data = mem[imem_addr[IMEM_AW-1:0]];

endmodule

// ==== verilog/load_ctrl.sv ====
`timescale 1ns/1ps

module load_ctrl (
	input logic CLK,
	input logic rst,
	input logic load_req,
	input logic run_req,
	input cpu_pkg::byte_t in_data,
	input logic in_valid,
	output logic in_ready,
	input logic core_in_ready,
	output cpu_pkg::byte_t core_in_data,
	output logic core_in_valid,
	output cpu_pkg::mode_e mode,
	output logic start,
	output cpu_pkg::imem_wr_t imem_wr
);
	import cpu_pkg::*;

	logic [1:0] byte_cnt;
	pc_t word_addr;
	logic [23:0] pack;   // bytes 0..2 of the word in progress
	logic byte_in;

	assign byte_in = mode == MODE_LOAD && in_valid;

	assign in_ready = (mode == MODE_LOAD) ? 1'b1 : core_in_ready;
	assign core_in_data = in_data;
	assign core_in_valid = mode == MODE_EXEC && in_valid;

	// fourth byte completes the word, write goes out on the same edge
	assign imem_wr.en = byte_in && byte_cnt == 2'd3 && !load_req;
	assign imem_wr.addr = word_addr;
	assign imem_wr.data = {in_data, pack};

	always_ff @(posedge CLK) begin
		if (rst) begin
			mode <= MODE_LOAD;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (load_req) begin
				mode <= MODE_LOAD;
			end else if (run_req) begin
				mode <= MODE_EXEC;
				start <= mode == MODE_LOAD;   // pulse on entry only
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			byte_cnt <= '0;
			word_addr <= '0;
		end else if (load_req) begin
			byte_cnt <= '0;
			word_addr <= '0;
		end else if (byte_in) begin
			byte_cnt <= byte_cnt + 2'd1;
			if (byte_cnt == 2'd3)
				word_addr <= word_addr + pc_t'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (byte_in)
			pack <= {in_data, pack[23:8]};   // little-endian shift in
	end

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	// ******************************
	// widths
	// ******************************
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] pc_t;     // word address
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// ******************************
	// encodings
	// ******************************
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_JAL     = 6'b000011;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_SW      = 6'b101011;
	localparam opcode_t OP_IN      = 6'b011010;
	localparam opcode_t OP_OUT     = 6'b011011;

	localparam funct_t FUNCT_ADD  = 6'b100000;
	localparam funct_t FUNCT_SUB  = 6'b100010;
	localparam funct_t FUNCT_AND  = 6'b100100;
	localparam funct_t FUNCT_OR   = 6'b100101;
	localparam funct_t FUNCT_NOR  = 6'b100111;
	localparam funct_t FUNCT_SLL  = 6'b000000;
	localparam funct_t FUNCT_SRL  = 6'b000010;
	localparam funct_t FUNCT_SLT  = 6'b101010;
	localparam funct_t FUNCT_JR   = 6'b001000;
	localparam funct_t FUNCT_JALR = 6'b001001;

	typedef enum logic {
		MODE_LOAD,
		MODE_EXEC
	} mode_e;

	typedef enum logic {
		ST_ISSUE,
		ST_LOAD_WAIT
	} exec_state_e;

	typedef struct packed {
		logic en;
		pc_t addr;
		word_t data;
	} imem_wr_t;

	typedef struct packed {
		logic we;
		word_t addr;   // word address, not bytes
		word_t wdata;
	} dmem_req_t;

	typedef struct packed {
		opcode_t opcode;
		funct_t funct;
		logic [4:0] shamt;
		logic [15:0] imm;
		word_t a;
		word_t b;
	} alu_op_t;

endpackage
